// File: design/sdram_defs.svh
`ifndef SDRAM_DEFS_SVH
`define SDRAM_DEFS_SVH

// Device geometry.
`define SDRAM_DATA_BITS       16
`define SDRAM_BANK_BITS       2
`define SDRAM_ROW_BITS        13
`define SDRAM_COL_BITS        9
`define SDRAM_MODEL_ROW_BITS  4

// Mode register contents. CAS latency 3 is also legal.
`define SDRAM_BURST_LEN       4
`define SDRAM_BL_CODE         2
`define SDRAM_CAS_LATENCY     2

// Timing in clock cycles.
`define SDRAM_TRCD            2
`define SDRAM_TRP             2
`define SDRAM_TMRD            2
`define SDRAM_INIT_CYCLES     20

// Commands as {ras, cas, we}, valid with cs low.
`define SDRAM_CMD_ACTIVE      3'b011
`define SDRAM_CMD_READ        3'b101
`define SDRAM_CMD_WRITE       3'b100
`define SDRAM_CMD_PRECHARGE   3'b010
`define SDRAM_CMD_MODE        3'b000
`define SDRAM_CMD_NOP         3'b111

`endif

// File: design/sdram_pkg.sv
`include "sdram_defs.svh"

package sdram_pkg;

  typedef logic [`SDRAM_DATA_BITS-1:0]   word_t;
  typedef logic [`SDRAM_BANK_BITS-1:0]   bank_t;
  typedef logic [`SDRAM_ROW_BITS-1:0]    row_t;
  typedef logic [`SDRAM_COL_BITS-1:0]    col_t;

  // One bit per byte, 1 means the byte is written.
  typedef logic [`SDRAM_DATA_BITS/8-1:0] byte_mask_t;

  // Word 0 of the burst sits in the low bits.
  typedef logic [`SDRAM_BURST_LEN*`SDRAM_DATA_BITS-1:0] burst_data_t;

  typedef struct packed {
    logic       cke;
    logic       cs;
    logic       ras;
    logic       cas;
    logic       we;
    row_t       a;
    bank_t      ba;
    byte_mask_t dqm;
  } sdram_pins_t;

  typedef struct packed {
    logic        write;
    bank_t       bank;
    row_t        row;
    col_t        col;
    byte_mask_t  wmask;
    burst_data_t wdata;
  } user_req_t;

  typedef enum logic [3:0] {
    INIT_WAIT, INIT_PRECHARGE, INIT_MODE,
    IDLE, ACTIVATE, RCD_WAIT,
    WRITE_BURST, READ_CMD, READ_WAIT,
    PRECHARGE, RP_WAIT
  } ctrl_state_t;

endpackage

// File: design/sdram_model.sv
`timescale 1ns/10ps
`include "sdram_defs.svh"

module sdram_model (
  input  logic                   clk,
  input  sdram_pkg::sdram_pins_t pins,
  inout  wire sdram_pkg::word_t  dq
);
  import sdram_pkg::*;

  localparam int BANKS = 1 << $bits(bank_t);
  localparam int ROWS  = 1 << `SDRAM_MODEL_ROW_BITS;
  localparam int COLS  = 1 << `SDRAM_COL_BITS;

  word_t mem [BANKS][ROWS][COLS];

  logic sel;
  logic cmd_active;
  logic cmd_read;
  logic cmd_write;
  logic cmd_mode;

  bank_t                           bank_q;
  logic [`SDRAM_MODEL_ROW_BITS-1:0] row_q;

  // Power-up state of the device, there is no reset pin.
  logic [2:0] bl_code = '0;
  logic [2:0] cas_lat = '0;
  logic [3:0] rd_left = '0;
  logic [3:0] wr_left = '0;
  logic [2:0] rd_vld  = '0;

  logic [3:0] burst_len;
  col_t       wrap_mask;

  col_t       rd_col;
  logic [3:0] rd_beat;
  logic       rd_fetch;
  col_t       rd_addr;
  word_t      rd_pipe [3];

  col_t       wr_col;
  logic [3:0] wr_beat;
  logic       wr_en;
  col_t       wr_addr;
  word_t      wr_old;
  word_t      wr_word;

  logic       dq_oe;
  word_t      rd_word;

  function automatic col_t burst_col(col_t base, logic [3:0] beat, col_t mask);
    col_t step;
    step = base + col_t'(beat);
    return (base & ~mask) | (step & mask);
  endfunction

  assign sel        = pins.cke && !pins.cs;
  assign cmd_active = sel && ({pins.ras, pins.cas, pins.we} == `SDRAM_CMD_ACTIVE);
  assign cmd_read   = sel && ({pins.ras, pins.cas, pins.we} == `SDRAM_CMD_READ);
  assign cmd_write  = sel && ({pins.ras, pins.cas, pins.we} == `SDRAM_CMD_WRITE);
  assign cmd_mode   = sel && ({pins.ras, pins.cas, pins.we} == `SDRAM_CMD_MODE);

  always_ff @(posedge clk) begin
    if (cmd_active) begin
      bank_q <= pins.ba;
      row_q  <= pins.a[`SDRAM_MODEL_ROW_BITS-1:0];
    end
    if (cmd_mode) begin
      bl_code <= pins.a[2:0];
      cas_lat <= pins.a[6:4];
    end
  end

  // Full page bursts are not modelled.
  always_comb begin
    case (bl_code)
      3'd1:    burst_len = 4'd2;
      3'd2:    burst_len = 4'd4;
      3'd3:    burst_len = 4'd8;
      default: burst_len = 4'd1;
    endcase
  end

  assign wrap_mask = col_t'(burst_len - 4'd1);

  // Read path, one fetch per beat, then delayed by the CAS latency.
  assign rd_fetch = cmd_read || (rd_left != 4'd0);
  assign rd_addr  = cmd_read ? pins.a[`SDRAM_COL_BITS-1:0] : burst_col(rd_col, rd_beat, wrap_mask);

  always_ff @(posedge clk) begin
    if (cmd_read) begin
      rd_col  <= pins.a[`SDRAM_COL_BITS-1:0];
      rd_beat <= 4'd1;
      rd_left <= burst_len - 4'd1;
    end else if (rd_left != 4'd0) begin
      rd_beat <= rd_beat + 4'd1;
      rd_left <= rd_left - 4'd1;
    end
    rd_pipe[0] <= mem[bank_q][row_q][rd_addr];
    rd_pipe[1] <= rd_pipe[0];
    rd_pipe[2] <= rd_pipe[1];
    rd_vld     <= {rd_vld[1:0], rd_fetch};
  end

  // Write path, bytes with dqm high take the bus value.
  assign wr_en   = cmd_write || (wr_left != 4'd0);
  assign wr_addr = cmd_write ? pins.a[`SDRAM_COL_BITS-1:0] : burst_col(wr_col, wr_beat, wrap_mask);
  assign wr_old  = mem[bank_q][row_q][wr_addr];
  assign wr_word = {pins.dqm[1] ? dq[15:8] : wr_old[15:8],
                    pins.dqm[0] ? dq[7:0]  : wr_old[7:0]};

  always_ff @(posedge clk) begin
    if (cmd_write) begin
      wr_col  <= pins.a[`SDRAM_COL_BITS-1:0];
      wr_beat <= 4'd1;
      wr_left <= burst_len - 4'd1;
    end else if (wr_left != 4'd0) begin
      wr_beat <= wr_beat + 4'd1;
      wr_left <= wr_left - 4'd1;
    end
    if (wr_en) begin
      mem[bank_q][row_q][wr_addr] <= wr_word;
    end
  end

  assign dq_oe   = (cas_lat == 3'd3) ? rd_vld[2] : rd_vld[1];
  assign rd_word = (cas_lat == 3'd3) ? rd_pipe[2] : rd_pipe[1];
  assign dq      = dq_oe ? rd_word : 'z;

endmodule

// File: design/sdram_ctrl.sv
`timescale 1ns/10ps
`include "sdram_defs.svh"

module sdram_ctrl (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   req_valid,
  input  sdram_pkg::user_req_t   req,
  output logic                   ready,
  output logic                   rd_valid,
  output sdram_pkg::burst_data_t rd_data,
  output sdram_pkg::sdram_pins_t pins,
  output sdram_pkg::word_t       dq_out,
  output logic                   dq_oe,
  input  sdram_pkg::word_t       dq_in
);
  import sdram_pkg::*;

  localparam int BEAT_BITS = $clog2(`SDRAM_BURST_LEN);
  localparam int WORD_BITS = $bits(word_t);
  localparam int DATA_BITS = $bits(burst_data_t);

  // Cycles from the READ edge to the edge that packs the last beat.
  localparam int CAP_SPAN = `SDRAM_CAS_LATENCY + `SDRAM_BURST_LEN + 1;

  // Sequential bursts, burst write, programmed latency and length.
  localparam row_t MODE_WORD = row_t'({3'(`SDRAM_CAS_LATENCY), 1'b0, 3'(`SDRAM_BL_CODE)});

  localparam sdram_pins_t DESELECT = '{cke: 1'b1, cs: 1'b1, ras: 1'b1, cas: 1'b1,
                                       we: 1'b1, default: '0};

  ctrl_state_t          state;
  user_req_t            req_q;
  logic [7:0]           delay_cnt;
  logic [BEAT_BITS-1:0] beat;
  logic [7:0]           cap_cnt;
  word_t                dq_q;

  function automatic sdram_pins_t command(logic [2:0] code, row_t a, bank_t ba,
                                          byte_mask_t dqm);
    sdram_pins_t p;
    p.cke = 1'b1;
    p.cs  = 1'b0;
    {p.ras, p.cas, p.we} = code;
    p.a   = a;
    p.ba  = ba;
    p.dqm = dqm;
    return p;
  endfunction

  assign ready = (state == IDLE);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= INIT_WAIT;
      delay_cnt <= 8'(`SDRAM_INIT_CYCLES - 1);
      beat      <= '0;
      pins      <= DESELECT;
      dq_oe     <= 1'b0;
    end else begin
      pins  <= command(`SDRAM_CMD_NOP, '0, '0, '0);
      dq_oe <= 1'b0;
      case (state)
        INIT_WAIT: begin
          pins <= DESELECT;
          if (delay_cnt == '0) begin
            state <= INIT_PRECHARGE;
          end else begin
            delay_cnt <= delay_cnt - 8'd1;
          end
        end
        INIT_PRECHARGE: begin
          // a[10] high closes all banks.
          pins      <= command(`SDRAM_CMD_PRECHARGE, row_t'(1 << 10), '0, '0);
          delay_cnt <= 8'(`SDRAM_TRP - 1);
          state     <= INIT_MODE;
        end
        INIT_MODE: begin
          if (delay_cnt != '0) begin
            delay_cnt <= delay_cnt - 8'd1;
          end else begin
            pins      <= command(`SDRAM_CMD_MODE, MODE_WORD, '0, '0);
            delay_cnt <= 8'(`SDRAM_TMRD - 1);
            state     <= RP_WAIT;
          end
        end
        IDLE: begin
          if (req_valid) begin
            state <= ACTIVATE;
          end
        end
        ACTIVATE: begin
          pins      <= command(`SDRAM_CMD_ACTIVE, req_q.row, req_q.bank, '0);
          delay_cnt <= 8'(`SDRAM_TRCD - 1);
          state     <= RCD_WAIT;
        end
        RCD_WAIT: begin
          beat <= '0;
          if (delay_cnt <= 8'd1) begin
            state <= req_q.write ? WRITE_BURST : READ_CMD;
          end else begin
            delay_cnt <= delay_cnt - 8'd1;
          end
        end
        WRITE_BURST: begin
          dq_oe <= 1'b1;
          if (beat == '0) begin
            pins <= command(`SDRAM_CMD_WRITE, row_t'(req_q.col), req_q.bank, req_q.wmask);
          end else begin
            pins <= command(`SDRAM_CMD_NOP, '0, '0, req_q.wmask);
          end
          beat <= beat + 1'b1;
          if (beat == BEAT_BITS'(`SDRAM_BURST_LEN - 1)) begin
            state <= PRECHARGE;
          end
        end
        READ_CMD: begin
          pins      <= command(`SDRAM_CMD_READ, row_t'(req_q.col), req_q.bank, '0);
          delay_cnt <= '0;
          state     <= READ_WAIT;
        end
        READ_WAIT: begin
          // Close the row right after the last beat leaves the device.
          if (delay_cnt == 8'(`SDRAM_CAS_LATENCY + `SDRAM_BURST_LEN - 2)) begin
            state <= PRECHARGE;
          end else begin
            delay_cnt <= delay_cnt + 8'd1;
          end
        end
        PRECHARGE: begin
          pins      <= command(`SDRAM_CMD_PRECHARGE, '0, req_q.bank, '0);
          delay_cnt <= 8'(`SDRAM_TRP - 1);
          state     <= RP_WAIT;
        end
        RP_WAIT: begin
          // Also serves as the mode-set delay after initialization.
          if (delay_cnt == '0) begin
            state <= IDLE;
          end else begin
            delay_cnt <= delay_cnt - 8'd1;
          end
        end
        default: state <= INIT_WAIT;
      endcase
    end
  end

  // Request hold and write word shifter.
  always_ff @(posedge clk) begin
    if (ready && req_valid) begin
      req_q <= req;
    end else if (state == WRITE_BURST) begin
      dq_out      <= req_q.wdata[WORD_BITS-1:0];
      req_q.wdata <= req_q.wdata >> WORD_BITS;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cap_cnt  <= '0;
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= 1'b0;
      if (state == READ_CMD) begin
        cap_cnt <= 8'(CAP_SPAN);
      end else if (cap_cnt != '0) begin
        cap_cnt  <= cap_cnt - 8'd1;
        rd_valid <= (cap_cnt == 8'd1);
      end
    end
  end

  // Beats are registered off the bus, then packed from the top down.
  always_ff @(posedge clk) begin
    dq_q <= dq_in;
    if (cap_cnt != '0 && cap_cnt <= 8'(`SDRAM_BURST_LEN)) begin
      rd_data <= {dq_q, rd_data[DATA_BITS-1:WORD_BITS]};
    end
  end

endmodule

// File: design/sdram_subsys.sv
`timescale 1ns/10ps

module sdram_subsys (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   req_valid,
  input  sdram_pkg::user_req_t   req,
  output logic                   ready,
  output logic                   rd_valid,
  output sdram_pkg::burst_data_t rd_data
);
  import sdram_pkg::*;

  sdram_pins_t pins;
  word_t       dq_out;
  logic        dq_oe;
  wire word_t  dq;

  // Controller side of the shared data bus.
  assign dq = dq_oe ? dq_out : 'z;

  sdram_ctrl u_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_valid (req_valid),
    .req       (req),
    .ready     (ready),
    .rd_valid  (rd_valid),
    .rd_data   (rd_data),
    .pins      (pins),
    .dq_out    (dq_out),
    .dq_oe     (dq_oe),
    .dq_in     (dq)
  );

  sdram_model u_model (
    .clk  (clk),
    .pins (pins),
    .dq   (dq)
  );

endmodule

// File: verification/sdram_sva.sv
`timescale 1ns/10ps
`include "sdram_defs.svh"

module sdram_sva (
  input logic                   clk,
  input logic                   rst_n,
  input logic                   req_valid,
  input sdram_pkg::user_req_t   req,
  input logic                   ready,
  input logic                   rd_valid,
  input sdram_pkg::sdram_pins_t pins,
  input logic                   ctrl_oe,
  input logic                   model_oe
);
  import sdram_pkg::*;

  // Cycles from acceptance to rd_valid of a read.
  localparam int RD_LAT  = 1 + `SDRAM_TRCD + `SDRAM_CAS_LATENCY + `SDRAM_BURST_LEN + 1;
  // The strobe of cycle RD_LAT is sampled one edge later.
  localparam int RD_SPAN = RD_LAT + 1;
  // ACTIVATE, tRCD and the data beats.
  localparam int BUSY = 1 + `SDRAM_TRCD + `SDRAM_BURST_LEN;

  logic accept;

  assign accept = ready && req_valid;

  cs_in_reset: assert property (@(posedge clk) !rst_n |-> pins.cs)
    else $error("chip select low during reset");

  no_read_after_write: assert property (@(posedge clk) disable iff (!rst_n)
      (accept && req.write) |=> !rd_valid [*RD_SPAN])
    else $error("rd_valid after an accepted write");

  dq_one_driver: assert property (@(posedge clk) disable iff (!rst_n) !(ctrl_oe && model_oe))
    else $error("controller and model drive dq together");

  busy_not_ready: assert property (@(posedge clk) disable iff (!rst_n)
      accept |=> !ready [*BUSY])
    else $error("ready high before the burst finished");

endmodule

bind sdram_subsys sdram_sva u_sva (
  .clk       (clk),
  .rst_n     (rst_n),
  .req_valid (req_valid),
  .req       (req),
  .ready     (ready),
  .rd_valid  (rd_valid),
  .pins      (pins),
  .ctrl_oe   (dq_oe),
  .model_oe  (u_model.dq_oe)
);

// File: verification/sdram_tb.sv
`timescale 1ns/10ps
`include "sdram_defs.svh"

module sdram_tb;
  import sdram_pkg::*;

  localparam int LIMIT = 500;
  localparam int SROWS = 1 << `SDRAM_MODEL_ROW_BITS;
  localparam int SCOLS = 1 << `SDRAM_COL_BITS;

  logic        clk;
  logic        rst_n;
  logic        req_valid;
  user_req_t   req;
  logic        ready;
  logic        rd_valid;
  burst_data_t rd_data;

  logic [15:0] lfsr;
  word_t       shadow [4][SROWS][SCOLS];
  logic        known  [4][SROWS][SCOLS];
  int          tests_run;
  int          checks;
  int          errors;

  sdram_subsys uut (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Galois form of x^16 + x^14 + x^13 + x^11 + 1.
  function automatic logic [15:0] lfsr_next(logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic logic [63:0] take_bits(int n);
    logic [63:0] v;
    int          i;
    v = '0;
    for (i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v[i] = lfsr[0];
    end
    return v;
  endfunction

  // Columns of a burst wrap inside their aligned group.
  function automatic col_t beat_col(col_t c, int k);
    return col_t'(c - c % `SDRAM_BURST_LEN + (c + k) % `SDRAM_BURST_LEN);
  endfunction

  task automatic note_error(string msg);
    $display("%s", msg);
    errors++;
  endtask

  // Applies the DQM rule to the shadow copy. A mask of 0 only reads it.
  task automatic shadow_access(input bank_t b, input row_t r, input col_t c,
                               input byte_mask_t m, input burst_data_t d,
                               output burst_data_t q, output bit full);
    logic [`SDRAM_MODEL_ROW_BITS-1:0] sr;
    col_t                             a;
    int                               k;
    sr   = r[`SDRAM_MODEL_ROW_BITS-1:0];
    full = 1'b1;
    for (k = 0; k < `SDRAM_BURST_LEN; k++) begin
      a = beat_col(c, k);
      if (m[0]) shadow[b][sr][a][7:0] = d[16*k +: 8];
      if (m[1]) shadow[b][sr][a][15:8] = d[16*k+8 +: 8];
      if (m == 2'b11) known[b][sr][a] = 1'b1;
      full = full && (known[b][sr][a] === 1'b1);
      q[16*k +: 16] = shadow[b][sr][a];
    end
  endtask

  task automatic issue(input user_req_t r, output bit ok);
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (ready !== 1'b1 && n < LIMIT);
    ok = (ready === 1'b1);
    if (!ok) begin
      note_error($sformatf("ERROR: timeout, ready stayed low for %0d cycles", LIMIT));
    end else begin
      @(posedge clk);
      req_valid <= 1'b1;
      req       <= r;
      @(posedge clk);
      req_valid <= 1'b0;
    end
  endtask

  task automatic write_burst(bank_t b, row_t r, col_t c, byte_mask_t m, burst_data_t d);
    burst_data_t q;
    bit          full;
    bit          ok;
    issue('{write: 1'b1, bank: b, row: r, col: c, wmask: m, wdata: d}, ok);
    if (ok) shadow_access(b, r, c, m, d, q, full);
  endtask

  task automatic make_known(bank_t b, row_t r, col_t c);
    burst_data_t q;
    bit          full;
    shadow_access(b, r, c, '0, '0, q, full);
    if (!full) write_burst(b, r, c, 2'b11, take_bits(64));
  endtask

  task automatic check_read(input string name, input bank_t b, input row_t r, input col_t c,
                            output burst_data_t got);
    burst_data_t exp;
    bit          full;
    bit          ok;
    int          n;
    got = 'x;
    issue('{write: 1'b0, bank: b, row: r, col: c, default: '0}, ok);
    if (!ok) return;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (rd_valid !== 1'b1 && n < LIMIT);
    checks++;
    if (rd_valid !== 1'b1) begin
      note_error($sformatf("ERROR: %s, no read data within %0d cycles", name, LIMIT));
      return;
    end
    got = rd_data;
    shadow_access(b, r, c, '0, '0, exp, full);
    if (got !== exp) begin
      note_error($sformatf("FAILED %s: bank %0d row %0h col %0h expected %h actual %h",
                           name, b, r, c, exp, got));
    end
  endtask

  task automatic end_test(string name, int start);
    tests_run++;
    if (errors == start) $display("test %s: ok", name);
    else $display("test %s: %0d errors", name, errors - start);
  endtask

  task automatic test_init();
    int start;
    int n;
    start = errors;
    @(posedge clk);
    rst_n <= 1'b0;
    repeat (10) begin
      @(negedge clk);
      checks++;
      if (ready !== 1'b0) note_error("ERROR: ready is not low during reset");
    end
    @(posedge clk);
    rst_n <= 1'b1;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (ready !== 1'b1 && n < LIMIT);
    checks++;
    if (ready !== 1'b1) begin
      note_error("ERROR: ready never rose after reset");
    end else if (n <= `SDRAM_INIT_CYCLES) begin
      note_error($sformatf("ERROR: ready rose %0d cycles after reset, before init", n));
    end
    end_test("init", start);
  endtask

  task automatic test_bursts();
    int          start;
    burst_data_t got;
    start = errors;
    write_burst(2'd1, 13'h0123, 9'h010, 2'b11, 64'h4444_3333_2222_1111);
    check_read("full_burst", 2'd1, 13'h0123, 9'h010, got);
    end_test("full_burst", start);
    // Masked writes over known data, the second one wraps in the group.
    start = errors;
    write_burst(2'd2, 13'h0055, 9'h020, 2'b11, {4{16'hA5A5}});
    write_burst(2'd2, 13'h0055, 9'h020, 2'b01, 64'h1111_2222_3333_4444);
    check_read("mask_low", 2'd2, 13'h0055, 9'h020, got);
    write_burst(2'd2, 13'h0055, 9'h022, 2'b10, 64'h9999_8888_7777_6666);
    check_read("mask_high", 2'd2, 13'h0055, 9'h020, got);
    end_test("byte_mask", start);
  endtask

  task automatic test_banks();
    int          start;
    int          b;
    burst_data_t got;
    start = errors;
    for (b = 0; b < 4; b++) begin
      write_burst(bank_t'(b), 13'h00A0, 9'h040, 2'b11, {4{word_t'(16'hB000 + b)}});
    end
    for (b = 0; b < 4; b++) begin
      check_read("banks", bank_t'(b), 13'h00A0, 9'h040, got);
    end
    write_burst(2'd3, 13'd3, 9'h080, 2'b11, {4{16'h0303}});
    write_burst(2'd3, 13'd19, 9'h080, 2'b11, {4{16'h1919}});
    check_read("alias", 2'd3, 13'd3, 9'h080, got);
    checks++;
    if (got !== {4{16'h1919}}) begin
      note_error($sformatf("FAILED alias: expected %h actual %h", {4{16'h1919}}, got));
    end
    end_test("banks", start);
  endtask

  task automatic test_random();
    int          start;
    int          i;
    bank_t       b;
    row_t        r;
    col_t        c;
    byte_mask_t  m;
    burst_data_t d;
    burst_data_t got;
    start = errors;
    for (i = 0; i < 20; i++) begin
      b = bank_t'(take_bits(2));
      r = row_t'(take_bits(13));
      c = col_t'(take_bits(9));
      m = byte_mask_t'(take_bits(2));
      d = take_bits(64);
      if (m != 2'b11) make_known(b, r, c);
      write_burst(b, r, c, m, d);
      check_read("random", b, r, c, got);
    end
    end_test("random", start);
  endtask

  task automatic test_ignored();
    int          start;
    burst_data_t got;
    start = errors;
    make_known(2'd2, 13'h0100, 9'h028);
    write_burst(2'd1, 13'h0007, 9'h008, 2'b11, 64'h7777_6666_5555_4444);
    @(negedge clk);
    checks++;
    if (ready !== 1'b0) note_error("ERROR: ready is high while a burst is in progress");
    @(posedge clk);
    req_valid <= 1'b1;
    req       <= '{write: 1'b1, bank: 2'd2, row: 13'h0100, col: 9'h028, wmask: 2'b11,
                   wdata: {4{16'hDEAD}}};
    @(posedge clk);
    req_valid <= 1'b0;
    check_read("ignored", 2'd2, 13'h0100, 9'h028, got);
    check_read("ignored_busy", 2'd1, 13'h0007, 9'h008, got);
    end_test("ignored", start);
  endtask

  initial begin
    rst_n     = 1'b1;
    req_valid = 1'b0;
    req       = '0;
    lfsr      = 16'd42;
    tests_run = 0;
    checks    = 0;
    errors    = 0;
    test_init();
    test_bursts();
    test_banks();
    test_random();
    test_ignored();
    $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: list.f
+incdir+design
design/sdram_pkg.sv
design/sdram_model.sv
design/sdram_ctrl.sv
design/sdram_subsys.sv
verification/sdram_sva.sv
verification/sdram_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds and runs the SDRAM subsystem testbench with Verilator.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module sdram_tb -f list.f -o sdram_tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sdram_tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation run returned status $status"
  exit 1
fi

if grep -q "^Simulation passed$" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1
